// ==== design/card_id_pkg.sv ====
`default_nettype none

package card_id_pkg;

	//////////////////////////////////////////////////
	// Function identity, one set per PCI function
	localparam logic [15:0] NIC_VENDORID  = 16'h0706;
	localparam logic [15:0] NIC_DEVICEID  = 16'h3B00;
	localparam logic [15:0] NIC_SUBVID    = 16'h10EE;
	localparam logic [15:0] NIC_SUBSYSID  = 16'h0050;
	localparam logic [23:0] NIC_CLASSCODE = 24'h020000;

	localparam logic [15:0] CAN_VENDORID  = 16'h0706;
	localparam logic [15:0] CAN_DEVICEID  = 16'h3B02;
	localparam logic [15:0] CAN_SUBVID    = 16'h13FE;
	localparam logic [15:0] CAN_SUBSYSID  = 16'hC202;
	localparam logic [23:0] CAN_CLASSCODE = 24'h0C0900;

	localparam logic [15:0] UART_VENDORID  = 16'h0706;
	localparam logic [15:0] UART_DEVICEID  = 16'h3B01;
	localparam logic [15:0] UART_SUBVID    = 16'h12E0;
	localparam logic [15:0] UART_SUBSYSID  = 16'h0031;
	localparam logic [23:0] UART_CLASSCODE = 24'h070200;

	// MAC address is OUI in the top three bytes, serial below
	localparam logic [23:0] NIC_MAC_OUI    = 24'hEC3F05;
	localparam logic [23:0] NIC_MAC_SERIAL = 24'h5A0001;
	localparam logic [47:0] NIC_MAC_ADDR   = {NIC_MAC_OUI, NIC_MAC_SERIAL};

	//////////////////////////////////////////////////
	// Register map
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	localparam logic [ADDR_W-1:0] REG_NIC_ID     = 8'h00;
	localparam logic [ADDR_W-1:0] REG_NIC_SUB    = 8'h04;
	localparam logic [ADDR_W-1:0] REG_NIC_CLASS  = 8'h08;
	localparam logic [ADDR_W-1:0] REG_CAN_ID     = 8'h10;
	localparam logic [ADDR_W-1:0] REG_CAN_SUB    = 8'h14;
	localparam logic [ADDR_W-1:0] REG_CAN_CLASS  = 8'h18;
	localparam logic [ADDR_W-1:0] REG_UART_ID    = 8'h20;
	localparam logic [ADDR_W-1:0] REG_UART_SUB   = 8'h24;
	localparam logic [ADDR_W-1:0] REG_UART_CLASS = 8'h28;
	localparam logic [ADDR_W-1:0] REG_LINK       = 8'h30;
	localparam logic [ADDR_W-1:0] REG_EVENT      = 8'h34;
	localparam logic [ADDR_W-1:0] REG_MAC_LO     = 8'h38;
	localparam logic [ADDR_W-1:0] REG_MAC_HI     = 8'h3C;

	// AXI read response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_t;

endpackage

`default_nettype wire

// ==== design/link_pkg.sv ====
`default_nettype none

package link_pkg;

	// PHY negotiated speed, same encoding as the PHY status pins
	typedef enum logic [1:0] {
		SPEED_10   = 2'd0,
		SPEED_100  = 2'd1,
		SPEED_1000 = 2'd2
	} speed_t;

	//////////////////////////////////////////////////
	// Selected link status, 5 bits
	typedef struct packed {
		logic   up;
		speed_t speed;
		logic   duplex;
		logic   port;
	} link_status_t;

	// An event is a snapshot of the status at the time of the change
	typedef link_status_t link_event_t;

	// Entries in the link event queue
	localparam int EVENT_DEPTH = 4;

endpackage

`default_nettype wire

// ==== design/phy_failover.sv ====
`default_nettype none

module phy_failover (
	input  logic                  pci_clk,
	input  logic                  reset_i,
	input  logic                  phy0_up_i,
	input  link_pkg::speed_t      phy0_speed_i,
	input  logic                  phy0_duplex_i,
	input  logic                  phy1_up_i,
	input  link_pkg::speed_t      phy1_speed_i,
	input  logic                  phy1_duplex_i,
	input  logic                  evt_ready_i,
	output link_pkg::link_status_t status_o,
	output logic                  sdp6_o,
	output logic                  sdp7_o,
	output logic                  evt_valid_o,
	output link_pkg::link_event_t evt_data_o
);

	import link_pkg::*;

	logic         up0_q, up1_q;
	speed_t       speed0_q, speed1_q;
	logic         duplex0_q, duplex1_q;
	logic         port_q;
	logic         port_d;
	logic         cur_up, oth_up;
	link_status_t status;
	link_status_t reported_q;
	logic         evt_valid_q;
	link_event_t  evt_data_q;
	logic         raise;

	//////////////////////////////////////////////////
	// Port selection
	// Stay on the current port while it is up, swap only to a live port
	assign cur_up = port_q ? phy1_up_i : phy0_up_i;
	assign oth_up = port_q ? phy0_up_i : phy1_up_i;
	assign port_d = (!cur_up && oth_up) ? ~port_q : port_q;

	always_ff @(posedge pci_clk) begin
		if (reset_i) begin
			up0_q     <= 1'b0;
			up1_q     <= 1'b0;
			speed0_q  <= SPEED_10;
			speed1_q  <= SPEED_10;
			duplex0_q <= 1'b0;
			duplex1_q <= 1'b0;
			port_q    <= 1'b0;
		end else begin
			up0_q     <= phy0_up_i;
			up1_q     <= phy1_up_i;
			speed0_q  <= phy0_speed_i;
			speed1_q  <= phy1_speed_i;
			duplex0_q <= phy0_duplex_i;
			duplex1_q <= phy1_duplex_i;
			port_q    <= port_d;
		end
	end

	always_comb begin
		status.up     = port_q ? up1_q : up0_q;
		status.speed  = port_q ? speed1_q : speed0_q;
		status.duplex = port_q ? duplex1_q : duplex0_q;
		status.port   = port_q;
	end

	assign status_o = status;
	// GPI lines tell the NIC which port carries the link
	assign sdp6_o   = status.up && (status.port == 1'b0);
	assign sdp7_o   = status.up && (status.port == 1'b1);

	//////////////////////////////////////////////////
	// Link change events
	assign raise = !evt_valid_q && (status != reported_q);

	always_ff @(posedge pci_clk) begin
		if (reset_i) begin
			evt_valid_q <= 1'b0;
			reported_q  <= '0;
		end else if (evt_valid_q) begin
			if (evt_ready_i)
				evt_valid_q <= 1'b0;
		end else if (raise) begin
			evt_valid_q <= 1'b1;
			reported_q  <= status;
		end
	end

	always_ff @(posedge pci_clk) begin
		if (raise)
			evt_data_q <= status;
	end

	assign evt_valid_o = evt_valid_q;
	assign evt_data_o  = evt_data_q;

	a_evt_hold: assert property (@(posedge pci_clk) disable iff (reset_i)
		evt_valid_o && !evt_ready_i |=> evt_valid_o && $stable(evt_data_o))
		else $error("event payload changed while waiting for ready");

endmodule

`default_nettype wire

// ==== design/event_fifo.sv ====
`default_nettype none

module event_fifo #(
	parameter int DEPTH = link_pkg::EVENT_DEPTH
) (
	input  logic                  pci_clk,
	input  logic                  reset_i,
	input  logic                  in_valid_i,
	input  link_pkg::link_event_t in_data_i,
	output logic                  in_ready_o,
	input  logic                  pop_i,
	output logic                  out_valid_o,
	output link_pkg::link_event_t out_data_o
);

	import link_pkg::*;

	link_event_t                  mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]     wr_ptr;
	logic [$clog2(DEPTH)-1:0]     rd_ptr;
	logic [$clog2(DEPTH+1)-1:0]   count;
	logic                         push;
	logic                         pop;

	assign in_ready_o  = (count != DEPTH);
	assign out_valid_o = (count != 0);
	assign out_data_o  = mem[rd_ptr];

	assign push = in_valid_i && in_ready_o;
	assign pop  = pop_i && out_valid_o;

	// Storage
	always_ff @(posedge pci_clk) begin
		if (push)
			mem[wr_ptr] <= in_data_i;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge pci_clk) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The register block must only pop an entry it has seen
	a_no_empty_pop: assert property (@(posedge pci_clk) disable iff (reset_i)
		pop_i |-> out_valid_o)
		else $error("pop of empty event queue");

endmodule

`default_nettype wire

// ==== design/csr_axil_slave.sv ====
`default_nettype none

module csr_axil_slave (
	input  logic                             pci_clk,
	input  logic                             reset_i,
	input  logic [card_id_pkg::ADDR_W-1:0]   araddr_i,
	input  logic                             arvalid_i,
	output logic                             arready_o,
	output logic [card_id_pkg::DATA_W-1:0]   rdata_o,
	output card_id_pkg::axi_resp_t           rresp_o,
	output logic                             rvalid_o,
	input  logic                             rready_i,
	input  link_pkg::link_status_t           status_i,
	input  logic                             q_valid_i,
	input  link_pkg::link_event_t            q_data_i,
	output logic                             q_pop_o
);

	import card_id_pkg::*;

	logic [DATA_W-1:0] rd_data_d;
	axi_resp_t         rd_resp_d;
	logic              rd_pop_d;
	logic [DATA_W-1:0] rdata_q;
	axi_resp_t         rresp_q;
	logic              rvalid_q;
	logic              pop_pending_q;
	logic              ar_hs;
	logic              r_hs;

	// One read in flight, address accepted only with no response held
	assign arready_o = !rvalid_q;
	assign ar_hs     = arvalid_i && arready_o;
	assign r_hs      = rvalid_q && rready_i;

	//////////////////////////////////////////////////
	// Address decode
	always_comb begin
		rd_data_d = '0;
		rd_resp_d = RESP_OKAY;
		rd_pop_d  = 1'b0;
		case (araddr_i)
			REG_NIC_ID:     rd_data_d = {NIC_DEVICEID, NIC_VENDORID};
			REG_NIC_SUB:    rd_data_d = {NIC_SUBSYSID, NIC_SUBVID};
			REG_NIC_CLASS:  rd_data_d = {8'd0, NIC_CLASSCODE};
			REG_CAN_ID:     rd_data_d = {CAN_DEVICEID, CAN_VENDORID};
			REG_CAN_SUB:    rd_data_d = {CAN_SUBSYSID, CAN_SUBVID};
			REG_CAN_CLASS:  rd_data_d = {8'd0, CAN_CLASSCODE};
			REG_UART_ID:    rd_data_d = {UART_DEVICEID, UART_VENDORID};
			REG_UART_SUB:   rd_data_d = {UART_SUBSYSID, UART_SUBVID};
			REG_UART_CLASS: rd_data_d = {8'd0, UART_CLASSCODE};
			REG_LINK: begin
				rd_data_d = {{(DATA_W - $bits(status_i)){1'b0}}, status_i};
			end
			REG_EVENT: begin
				// Empty queue reads as zero
				if (q_valid_i) begin
					rd_data_d = {1'b1, {(DATA_W - 1 - $bits(q_data_i)){1'b0}}, q_data_i};
					rd_pop_d  = 1'b1;
				end
			end
			REG_MAC_LO:     rd_data_d = NIC_MAC_ADDR[31:0];
			REG_MAC_HI:     rd_data_d = {16'd0, NIC_MAC_ADDR[47:32]};
			default:        rd_resp_d = RESP_SLVERR;
		endcase
	end

	//////////////////////////////////////////////////
	// Read response channel
	always_ff @(posedge pci_clk) begin
		if (reset_i) begin
			rvalid_q      <= 1'b0;
			pop_pending_q <= 1'b0;
		end else if (ar_hs) begin
			rvalid_q      <= 1'b1;
			pop_pending_q <= rd_pop_d;
		end else if (r_hs) begin
			rvalid_q      <= 1'b0;
			pop_pending_q <= 1'b0;
		end
	end

	// Response payload, captured with the address
	always_ff @(posedge pci_clk) begin
		if (ar_hs) begin
			rdata_q <= rd_data_d;
			rresp_q <= rd_resp_d;
		end
	end

	assign rvalid_o = rvalid_q;
	assign rdata_o  = rdata_q;
	assign rresp_o  = rresp_q;

	// Head entry stays put until this pop, only this block pops
	assign q_pop_o = r_hs && pop_pending_q;

	a_r_stable: assert property (@(posedge pci_clk) disable iff (reset_i)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
		else $error("read response changed before handshake");

endmodule

`default_nettype wire

// ==== design/multi_card_top.sv ====
`default_nettype none

module multi_card_top (
	input  logic                           pci_clk,
	input  logic                           reset_i,

	// PHY link status
	input  logic                           phy0_up_i,
	input  link_pkg::speed_t               phy0_speed_i,
	input  logic                           phy0_duplex_i,
	input  logic                           phy1_up_i,
	input  link_pkg::speed_t               phy1_speed_i,
	input  logic                           phy1_duplex_i,

	// AXI4-Lite read channel
	input  logic [card_id_pkg::ADDR_W-1:0] s_axil_araddr_i,
	input  logic                           s_axil_arvalid_i,
	output logic                           s_axil_arready_o,
	output logic [card_id_pkg::DATA_W-1:0] s_axil_rdata_o,
	output card_id_pkg::axi_resp_t         s_axil_rresp_o,
	output logic                           s_axil_rvalid_o,
	input  logic                           s_axil_rready_i,

	// Link state and interrupt
	output logic                           active_port_o,
	output logic                           link_up_o,
	output logic                           sdp6_o,
	output logic                           sdp7_o,
	output logic                           link_irq_o
);

	import link_pkg::*;

	link_status_t status;
	logic         evt_valid;
	logic         evt_ready;
	link_event_t  evt_data;
	logic         q_valid;
	logic         q_pop;
	link_event_t  q_data;

	//////////////////////////////////////////////////
	// Dual PHY failover
	phy_failover phy_failover_i (
		.pci_clk       (pci_clk),
		.reset_i       (reset_i),
		.phy0_up_i     (phy0_up_i),
		.phy0_speed_i  (phy0_speed_i),
		.phy0_duplex_i (phy0_duplex_i),
		.phy1_up_i     (phy1_up_i),
		.phy1_speed_i  (phy1_speed_i),
		.phy1_duplex_i (phy1_duplex_i),
		.evt_ready_i   (evt_ready),
		.status_o      (status),
		.sdp6_o        (sdp6_o),
		.sdp7_o        (sdp7_o),
		.evt_valid_o   (evt_valid),
		.evt_data_o    (evt_data)
	);

	event_fifo #(.DEPTH(EVENT_DEPTH)) event_fifo_i (
		.pci_clk     (pci_clk),
		.reset_i     (reset_i),
		.in_valid_i  (evt_valid),
		.in_data_i   (evt_data),
		.in_ready_o  (evt_ready),
		.pop_i       (q_pop),
		.out_valid_o (q_valid),
		.out_data_o  (q_data)
	);

	//////////////////////////////////////////////////
	// Register block
	csr_axil_slave csr_axil_slave_i (
		.pci_clk   (pci_clk),
		.reset_i   (reset_i),
		.araddr_i  (s_axil_araddr_i),
		.arvalid_i (s_axil_arvalid_i),
		.arready_o (s_axil_arready_o),
		.rdata_o   (s_axil_rdata_o),
		.rresp_o   (s_axil_rresp_o),
		.rvalid_o  (s_axil_rvalid_o),
		.rready_i  (s_axil_rready_i),
		.status_i  (status),
		.q_valid_i (q_valid),
		.q_data_i  (q_data),
		.q_pop_o   (q_pop)
	);

	// Pending events raise the interrupt
	assign link_irq_o    = q_valid;
	assign active_port_o = status.port;
	assign link_up_o     = status.up;

endmodule

`default_nettype wire

// ==== testbench/tb_multi_card.sv ====
`default_nettype none

module tb_multi_card;

	import card_id_pkg::*;
	import link_pkg::*;

	localparam int TIMEOUT = 50;

	logic              pci_clk;
	logic              reset_i;
	logic              phy0_up;
	speed_t            phy0_speed;
	logic              phy0_duplex;
	logic              phy1_up;
	speed_t            phy1_speed;
	logic              phy1_duplex;
	logic [ADDR_W-1:0] s_axil_araddr;
	logic              s_axil_arvalid;
	logic              s_axil_arready;
	logic [DATA_W-1:0] s_axil_rdata;
	axi_resp_t         s_axil_rresp;
	logic              s_axil_rvalid;
	logic              s_axil_rready;
	logic              active_port;
	logic              link_up;
	logic              sdp6;
	logic              sdp7;
	logic              link_irq;

	// Model of the selected link and of the events still to be read
	link_status_t      model_status;
	link_event_t       exp_events[$];

	integer            seed;
	int                errors;
	int                test_errors;
	int                pass_count;
	int                fail_count;
	string             cur_test;

	// Shared with the compare process
	string             rd_name;
	logic [DATA_W-1:0] exp_data;
	axi_resp_t         exp_resp;
	logic [DATA_W-1:0] got_data;
	axi_resp_t         got_resp;

	multi_card_top DUT (
		.pci_clk          (pci_clk),
		.reset_i          (reset_i),
		.phy0_up_i        (phy0_up),
		.phy0_speed_i     (phy0_speed),
		.phy0_duplex_i    (phy0_duplex),
		.phy1_up_i        (phy1_up),
		.phy1_speed_i     (phy1_speed),
		.phy1_duplex_i    (phy1_duplex),
		.s_axil_araddr_i  (s_axil_araddr),
		.s_axil_arvalid_i (s_axil_arvalid),
		.s_axil_arready_o (s_axil_arready),
		.s_axil_rdata_o   (s_axil_rdata),
		.s_axil_rresp_o   (s_axil_rresp),
		.s_axil_rvalid_o  (s_axil_rvalid),
		.s_axil_rready_i  (s_axil_rready),
		.active_port_o    (active_port),
		.link_up_o        (link_up),
		.sdp6_o           (sdp6),
		.sdp7_o           (sdp7),
		.link_irq_o       (link_irq)
	);

	initial begin
		pci_clk = 1'b0;
		forever #4 pci_clk = ~pci_clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	function automatic void expected_read(input logic [ADDR_W-1:0] addr,
			output logic [DATA_W-1:0] data, output axi_resp_t resp);
		data = '0;
		resp = RESP_OKAY;
		case (addr)
			REG_NIC_ID:     data = {NIC_DEVICEID, NIC_VENDORID};
			REG_NIC_SUB:    data = {NIC_SUBSYSID, NIC_SUBVID};
			REG_NIC_CLASS:  data = {8'h00, NIC_CLASSCODE};
			REG_CAN_ID:     data = {CAN_DEVICEID, CAN_VENDORID};
			REG_CAN_SUB:    data = {CAN_SUBSYSID, CAN_SUBVID};
			REG_CAN_CLASS:  data = {8'h00, CAN_CLASSCODE};
			REG_UART_ID:    data = {UART_DEVICEID, UART_VENDORID};
			REG_UART_SUB:   data = {UART_SUBSYSID, UART_SUBVID};
			REG_UART_CLASS: data = {8'h00, UART_CLASSCODE};
			REG_LINK:       data = {27'd0, model_status};
			REG_EVENT: begin
				if (exp_events.size() > 0)
					data = {1'b1, 26'd0, exp_events[0]};
			end
			// MAC is OUI then serial, the low word ends with the serial
			REG_MAC_LO:     data = {NIC_MAC_OUI[7:0], NIC_MAC_SERIAL};
			REG_MAC_HI:     data = {16'h0000, NIC_MAC_OUI[23:8]};
			default:        resp = RESP_SLVERR;
		endcase
	endfunction

	// Only up and port reach the top level pins
	function automatic link_status_t port_view(input link_status_t st);
		link_status_t v;
		v = st;
		v.speed = SPEED_10;
		v.duplex = 1'b0;
		return v;
	endfunction

	function automatic logic pick_rready(input bit stall);
		return stall ? logic'($random(seed) & 1) : 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("Error [%s] %s: expected %h, actual %h", cur_test, name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
		if (act !== exp) begin
			errors++;
			$display("Error [%s] %s resp: expected %b, actual %b", cur_test, name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input link_status_t exp,
			input link_status_t act);
		if (act !== exp) begin
			errors++;
			$display("Error [%s] %s status: expected %b, actual %b", cur_test, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Error [%s] %s: expected %b, actual %b", cur_test, name, exp, act);
		end
	endtask

	// Checks every completed R handshake
	always @(posedge pci_clk) begin
		if (s_axil_rvalid === 1'b1 && s_axil_rready === 1'b1) begin
			got_data = s_axil_rdata;
			got_resp = s_axil_rresp;
			check_data(rd_name, exp_data, got_data);
			check_resp(rd_name, exp_resp, got_resp);
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	task automatic axil_read(input logic [ADDR_W-1:0] addr, input string name,
			input bit stall, output logic [DATA_W-1:0] data);
		int                n;
		bit                done;
		logic [DATA_W-1:0] hold_data;
		axi_resp_t         hold_resp;
		rd_name = name;
		expected_read(addr, exp_data, exp_resp);
		s_axil_araddr = addr;
		s_axil_arvalid = 1'b1;
		n = 0;
		done = 1'b0;
		while (!done && n < TIMEOUT) begin
			@(posedge pci_clk);
			done = (s_axil_arready === 1'b1);
			n++;
		end
		#1;
		s_axil_arvalid = 1'b0;
		data = 'x;
		if (!done) begin
			errors++;
			$display("Timeout in %s: address of %s was never accepted", cur_test, name);
			return;
		end
		s_axil_rready = pick_rready(stall);
		@(posedge pci_clk);
		if (s_axil_rvalid !== 1'b1) begin
			errors++;
			$display("In %s: rvalid for %s did not rise one cycle after the address",
				cur_test, name);
		end
		hold_data = s_axil_rdata;
		hold_resp = s_axil_rresp;
		done = (s_axil_rvalid === 1'b1 && s_axil_rready === 1'b1);
		n = 0;
		while (!done && n < TIMEOUT) begin
			#1;
			s_axil_rready = pick_rready(stall);
			@(posedge pci_clk);
			n++;
			done = (s_axil_rvalid === 1'b1 && s_axil_rready === 1'b1);
			if (s_axil_rvalid === 1'b1) begin
				check_data({name, " hold"}, hold_data, s_axil_rdata);
				check_resp({name, " hold"}, hold_resp, s_axil_rresp);
			end
		end
		#1;
		s_axil_rready = 1'b0;
		if (!done) begin
			errors++;
			$display("Timeout in %s: response to %s was never taken", cur_test, name);
		end else begin
			data = got_data;
		end
	endtask

	task automatic read_event(input string name);
		logic [DATA_W-1:0] data;
		axil_read(REG_EVENT, name, 1'b0, data);
		if (exp_events.size() > 0)
			void'(exp_events.pop_front());
	endtask

	// Drives both PHYs and applies the failover rule to the model
	task automatic set_phys(input logic up0, input speed_t sp0, input logic dx0,
			input logic up1, input speed_t sp1, input logic dx1);
		link_status_t new_status;
		phy0_up = up0;
		phy0_speed = sp0;
		phy0_duplex = dx0;
		phy1_up = up1;
		phy1_speed = sp1;
		phy1_duplex = dx1;
		new_status = model_status;
		if (!(new_status.port ? up1 : up0) && (new_status.port ? up0 : up1))
			new_status.port = ~new_status.port;
		new_status.up = new_status.port ? up1 : up0;
		new_status.speed = new_status.port ? sp1 : sp0;
		new_status.duplex = new_status.port ? dx1 : dx0;
		if (new_status != model_status)
			exp_events.push_back(new_status);
		model_status = new_status;
	endtask

	task automatic settle_link(input string name);
		link_status_t act_view;
		// Inputs are registered, the status follows one cycle later
		@(posedge pci_clk);
		#1;
		act_view = '0;
		act_view.up = link_up;
		act_view.port = active_port;
		check_status(name, port_view(model_status), act_view);
		// Event and queue entry take a cycle each
		repeat (2) @(posedge pci_clk);
		#1;
	endtask

	task automatic check_link(input string name);
		logic [DATA_W-1:0] data;
		settle_link(name);
		check_bit({name, " sdp6"}, model_status.up && !model_status.port, sdp6);
		check_bit({name, " sdp7"}, model_status.up && model_status.port, sdp7);
		axil_read(REG_LINK, {name, " REG_LINK"}, 1'b0, data);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			pass_count++;
			$display("%s: passed", cur_test);
		end else begin
			fail_count++;
			$display("%s: failed with %0d errors", cur_test, errors - test_errors);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	initial begin
		logic [DATA_W-1:0] data;
		logic [ADDR_W-1:0] id_addrs [11];
		logic [ADDR_W-1:0] tmp;
		int                j;
		link_status_t      final_status;

		seed = 50;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		model_status = '0;
		reset_i = 1'b1;
		set_phys(1'b0, SPEED_10, 1'b0, 1'b0, SPEED_10, 1'b0);
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;
		repeat (4) @(posedge pci_clk);
		#1;
		reset_i = 1'b0;

		start_test("identity registers");
		check_bit("reset arready", 1'b1, s_axil_arready);
		check_bit("reset rvalid", 1'b0, s_axil_rvalid);
		check_bit("reset irq", 1'b0, link_irq);
		check_bit("reset sdp6", 1'b0, sdp6);
		check_bit("reset sdp7", 1'b0, sdp7);
		check_bit("reset port", 1'b0, active_port);
		id_addrs = '{REG_NIC_ID, REG_NIC_SUB, REG_NIC_CLASS, REG_CAN_ID, REG_CAN_SUB,
			REG_CAN_CLASS, REG_UART_ID, REG_UART_SUB, REG_UART_CLASS, REG_MAC_LO, REG_MAC_HI};
		for (int i = 10; i > 0; i--) begin
			j = $unsigned($random(seed)) % (i + 1);
			tmp = id_addrs[i];
			id_addrs[i] = id_addrs[j];
			id_addrs[j] = tmp;
		end
		foreach (id_addrs[i])
			axil_read(id_addrs[i], $sformatf("read 0x%02h", id_addrs[i]), 1'b0, data);
		end_test();

		start_test("unmapped reads with stalls");
		axil_read(8'h0C, "read 0x0c", 1'b1, data);
		axil_read(8'h2C, "read 0x2c", 1'b1, data);
		axil_read(8'h40, "read 0x40", 1'b1, data);
		axil_read(8'hFF, "read 0xff", 1'b1, data);
		axil_read(REG_MAC_LO, "stalled MAC low", 1'b1, data);
		axil_read(REG_UART_ID, "stalled UART id", 1'b1, data);
		end_test();

		start_test("failover");
		set_phys(1'b1, SPEED_1000, 1'b1, 1'b0, SPEED_10, 1'b0);
		check_link("phy0 up");
		set_phys(1'b0, SPEED_1000, 1'b1, 1'b1, SPEED_100, 1'b1);
		check_link("phy0 down");
		set_phys(1'b1, SPEED_1000, 1'b1, 1'b1, SPEED_100, 1'b1);
		check_link("phy0 back");
		set_phys(1'b0, SPEED_1000, 1'b1, 1'b0, SPEED_100, 1'b1);
		check_link("both down");
		end_test();

		start_test("link events");
		check_bit("irq with events queued", 1'b1, link_irq);
		while (exp_events.size() > 0)
			read_event("queued failover event");
		set_phys(1'b0, SPEED_1000, 1'b1, 1'b1, SPEED_1000, 1'b1);
		settle_link("phy1 up");
		read_event("phy1 up event");
		set_phys(1'b0, SPEED_1000, 1'b1, 1'b1, SPEED_1000, 1'b0);
		settle_link("phy1 half duplex");
		read_event("half duplex event");
		set_phys(1'b1, SPEED_10, 1'b0, 1'b0, SPEED_1000, 1'b0);
		settle_link("swap to phy0");
		read_event("swap event");
		check_bit("irq after drain", 1'b0, link_irq);
		axil_read(REG_EVENT, "empty queue", 1'b0, data);
		end_test();

		start_test("back-pressure");
		for (int i = 0; i < 6; i++) begin
			set_phys(1'b1, speed_t'(2 - i % 3), (i % 2 == 0), 1'b0, SPEED_1000, 1'b0);
			settle_link($sformatf("change %0d", i));
			check_bit($sformatf("irq after change %0d", i), 1'b1, link_irq);
		end
		// Queue holds DEPTH, failover holds one more, later changes fold into one event
		final_status = model_status;
		while (exp_events.size() > EVENT_DEPTH + 1)
			void'(exp_events.pop_back());
		if (exp_events[$] != final_status)
			exp_events.push_back(final_status);
		while (exp_events.size() > 0)
			read_event("drained event");
		check_bit("irq after drain", 1'b0, link_irq);
		axil_read(REG_EVENT, "empty queue", 1'b0, data);
		end_test();

		$display("Tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/card_id_pkg.sv
design/link_pkg.sv
design/phy_failover.sv
design/event_fifo.sv
design/csr_axil_slave.sv
design/multi_card_top.sv
testbench/tb_multi_card.sv
